// File: logic/nnPkg.sv
`default_nettype none

package nnPkg;

	// Network shape
	localparam int pixelCount = 10;
	localparam int hiddenCount = 4;
	localparam int classCount = 3;
	localparam int classIdWidth = $clog2(classCount);

	// Fixed-point format of activations, biases and the accumulator
	localparam int actWidth = 8;
	localparam int biasWidth = 16;
	localparam int accWidth = 23;
	localparam int fracShift = 6;
	localparam int actMax = 127;

	// Stage latencies in clock cycles
	localparam int captureLatency = 1;
	localparam int nodeLatency = 3;
	localparam int selectLatency = 1;
	localparam int pipeLatency = captureLatency + 2 * nodeLatency + selectLatency;

	// One row per hidden neuron, one column per pixel
	localparam logic [0:hiddenCount-1][0:pixelCount-1][actWidth-1:0] hiddenWeights = '{
		'{ 8'sd3,   8'sd5,  -8'sd2,   8'sd4,   8'sd1,
		  -8'sd3,   8'sd6,   8'sd2,  -8'sd1,   8'sd3},
		'{-8'sd4,   8'sd2,   8'sd7,  -8'sd5,   8'sd3,
		   8'sd1,  -8'sd2,   8'sd4,   8'sd6,  -8'sd3},
		'{ 8'sd10, -8'sd8,   8'sd6,  -8'sd12,  8'sd9,
		  -8'sd7,   8'sd5,  -8'sd11,  8'sd8,  -8'sd6},
		// Row 3 is the node_3_3 weight set
		'{-8'sd20,  8'sd4,  -8'sd28,  8'sd28, -8'sd20,
		   8'sd46, -8'sd22, -8'sd48,  8'sd34, -8'sd22}
	};

	localparam logic [0:hiddenCount-1][biasWidth-1:0] hiddenBias = '{
		-16'sd256,
		16'sd128,
		-16'sd512,
		16'sd1024
	};

	// One row per class, one column per hidden neuron
	localparam logic [0:classCount-1][0:hiddenCount-1][actWidth-1:0] outputWeights = '{
		'{ 8'sd24, -8'sd10,  8'sd18, -8'sd8},
		'{-8'sd12,  8'sd30, -8'sd6,   8'sd16},
		'{ 8'sd14,  8'sd8,  -8'sd20,  8'sd22}
	};

	localparam logic [0:classCount-1][biasWidth-1:0] outputBias = '{
		16'sd64,
		-16'sd128,
		16'sd0
	};

endpackage

`default_nettype wire

// File: logic/pixelCapture.sv
`timescale 1ns/100ps
`default_nettype none

module pixelCapture (
	input logic clk,
	input logic reset,
	input logic sampleValid,
	input logic [nnPkg::pixelCount-1:0][nnPkg::actWidth-1:0] pixels,
	output logic actValid,
	output logic [nnPkg::pixelCount-1:0][nnPkg::actWidth-1:0] acts
);
	import nnPkg::*;

	// Halving keeps every activation in 0..127, so the signed neurons
	// never see a pixel with its top bit set
	logic [pixelCount-1:0][actWidth-1:0] halved;

	always_comb
	begin
		for (int i = 0; i < pixelCount; i++)
		begin
			halved[i] = pixels[i] >> 1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			actValid <= 1'b0;
			acts <= '0;
		end
		else
		begin
			actValid <= sampleValid;
			// Hold the last sample between strobes
			if (sampleValid)
				acts <= halved;
		end
	end

endmodule

`default_nettype wire

// File: logic/neuronNode.sv
`timescale 1ns/100ps
`default_nettype none

module neuronNode #(
	parameter int fanIn = nnPkg::pixelCount,
	parameter logic [0:fanIn-1][nnPkg::actWidth-1:0] nodeWeights = '0,
	parameter logic [nnPkg::biasWidth-1:0] nodeBias = '0
) (
	input logic clk,
	input logic reset,
	input logic inValid,
	input logic [fanIn-1:0][nnPkg::actWidth-1:0] acts,
	output logic outValid,
	output logic [nnPkg::actWidth-1:0] act
);
	import nnPkg::*;

	localparam int prodWidth = 2 * actWidth;

	logic [fanIn-1:0][actWidth-1:0] actsReg;
	logic signed [prodWidth-1:0] products [fanIn];
	logic signed [accWidth-1:0] sumNext;
	logic signed [accWidth-1:0] sumReg;
	logic [accWidth-1:0] rounded;
	logic [nodeLatency-1:0] validPipe;

	// Signed 8x8 products of the registered inputs
	always_comb
	begin
		for (int i = 0; i < fanIn; i++)
		begin
			products[i] = $signed(actsReg[i]) * $signed(nodeWeights[i]);
		end
	end

	// Bias plus products, each sign-extended to the accumulator width
	always_comb
	begin
		sumNext = {{(accWidth-biasWidth){nodeBias[biasWidth-1]}}, nodeBias};
		for (int i = 0; i < fanIn; i++)
		begin
			sumNext = sumNext + {{(accWidth-prodWidth){products[i][prodWidth-1]}}, products[i]};
		end
	end

	// Drop the fraction bits and round half up
	// only meaningful while sumReg is non-negative
	assign rounded = {{fracShift{1'b0}}, sumReg[accWidth-1:fracShift]}
		+ accWidth'(sumReg[fracShift-1]);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			actsReg <= '0;
			sumReg <= '0;
			act <= '0;
			validPipe <= '0;
		end
		else
		begin
			validPipe <= {validPipe[nodeLatency-2:0], inValid};
			actsReg <= acts;
			sumReg <= sumNext;
			// ReLU, then saturate after rounding so 127.5 lands on 127
			if (sumReg[accWidth-1])
				act <= '0;
			else if (rounded > accWidth'(actMax))
				act <= actWidth'(actMax);
			else
				act <= rounded[actWidth-1:0];
		end
	end

	// Strobe depth matches the three data registers above
	assign outValid = validPipe[nodeLatency-1];

endmodule

`default_nettype wire

// File: logic/denseLayer.sv
`timescale 1ns/100ps
`default_nettype none

module denseLayer #(
	parameter int fanIn = nnPkg::pixelCount,
	parameter int nodeCount = nnPkg::hiddenCount,
	parameter logic [0:nodeCount-1][0:fanIn-1][nnPkg::actWidth-1:0] layerWeights = '0,
	parameter logic [0:nodeCount-1][nnPkg::biasWidth-1:0] layerBias = '0
) (
	input logic clk,
	input logic reset,
	input logic inValid,
	input logic [fanIn-1:0][nnPkg::actWidth-1:0] acts,
	output logic outValid,
	output logic [nodeCount-1:0][nnPkg::actWidth-1:0] outActs
);
	import nnPkg::*;

	logic [nodeCount-1:0] nodeValid;

	// Every neuron sees the full input vector and its own weight row
	for (genvar i = 0; i < nodeCount; i++)
	begin : g_node
		neuronNode #(
			.fanIn(fanIn),
			.nodeWeights(layerWeights[i]),
			.nodeBias(layerBias[i])
		) u_node (
			.clk(clk),
			.reset(reset),
			.inValid(inValid),
			.acts(acts),
			.outValid(nodeValid[i]),
			.act(outActs[i])
		);
	end

	// All neurons run in lockstep
	assign outValid = nodeValid[0];

endmodule

`default_nettype wire

// File: logic/classSelect.sv
`timescale 1ns/100ps
`default_nettype none

module classSelect (
	input logic clk,
	input logic reset,
	input logic scoreValid,
	input logic [nnPkg::classCount-1:0][nnPkg::actWidth-1:0] scores,
	output logic resultValid,
	output logic [nnPkg::classIdWidth-1:0] classId,
	output logic [nnPkg::actWidth-1:0] classScore
);
	import nnPkg::*;

	logic [classIdWidth-1:0] bestId;
	logic [actWidth-1:0] bestScore;

	// Strict compare in index order, so a tie keeps the lower index
	always_comb
	begin
		bestId = '0;
		bestScore = scores[0];
		for (int i = 1; i < classCount; i++)
		begin
			if (scores[i] > bestScore)
			begin
				bestId = classIdWidth'(i);
				bestScore = scores[i];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			resultValid <= 1'b0;
			classId <= '0;
			classScore <= '0;
		end
		else
		begin
			resultValid <= scoreValid;
			classId <= bestId;
			classScore <= bestScore;
		end
	end

endmodule

`default_nettype wire

// File: logic/nnClassifier.sv
`timescale 1ns/100ps
`default_nettype none

module nnClassifier (
	input logic clk,
	input logic reset,
	input logic sampleValid,
	input logic [nnPkg::pixelCount-1:0][nnPkg::actWidth-1:0] pixels,
	output logic resultValid,
	output logic [nnPkg::classIdWidth-1:0] classId,
	output logic [nnPkg::actWidth-1:0] classScore
);
	import nnPkg::*;

	logic actValid;
	logic [pixelCount-1:0][actWidth-1:0] acts;
	logic hiddenValid;
	logic [hiddenCount-1:0][actWidth-1:0] hiddenActs;
	logic scoreValid;
	logic [classCount-1:0][actWidth-1:0] scores;

	pixelCapture u_capture (
		.clk(clk),
		.reset(reset),
		.sampleValid(sampleValid),
		.pixels(pixels),
		.actValid(actValid),
		.acts(acts)
	);

	// Hidden layer with ten inputs and four neurons
	denseLayer #(
		.fanIn(pixelCount),
		.nodeCount(hiddenCount),
		.layerWeights(hiddenWeights),
		.layerBias(hiddenBias)
	) u_hidden (
		.clk(clk),
		.reset(reset),
		.inValid(actValid),
		.acts(acts),
		.outValid(hiddenValid),
		.outActs(hiddenActs)
	);

	// Output layer with one neuron per class
	denseLayer #(
		.fanIn(hiddenCount),
		.nodeCount(classCount),
		.layerWeights(outputWeights),
		.layerBias(outputBias)
	) u_output (
		.clk(clk),
		.reset(reset),
		.inValid(hiddenValid),
		.acts(hiddenActs),
		.outValid(scoreValid),
		.outActs(scores)
	);

	classSelect u_select (
		.clk(clk),
		.reset(reset),
		.scoreValid(scoreValid),
		.scores(scores),
		.resultValid(resultValid),
		.classId(classId),
		.classScore(classScore)
	);

endmodule

`default_nettype wire

// File: verification/nnClassifierChecker.sv
`timescale 1ns/100ps
`default_nettype none

module nnClassifierChecker (
	input logic clk,
	input logic reset,
	input logic sampleValid,
	input logic [nnPkg::pixelCount-1:0][nnPkg::actWidth-1:0] pixels,
	input int testId,
	input logic resultValid,
	input logic [nnPkg::classIdWidth-1:0] classId,
	input logic [nnPkg::actWidth-1:0] classScore,
	output int valueErrors,
	output int protocolErrors,
	output int checkedCount,
	output int pendingCount
);
	import nnPkg::*;

	int expIds[$];
	int expScores[$];
	int expTests[$];
	int expId;
	int expScore;
	int expTest;
	logic resetQ = 1'b0;
	logic resetQQ = 1'b0;

	initial
	begin
		valueErrors = 0;
		protocolErrors = 0;
		checkedCount = 0;
		pendingCount = 0;
	end

	// Ids follow the order of the test groups in nnClassifierTb
	function automatic string testName(input int id);
		case (id)
			0: return "corner";
			1: return "burst";
			2: return "negative";
			3: return "random";
			default: return "unknown";
		endcase
	endfunction

	// ReLU, round half up on the dropped fraction bits, then cap
	function automatic int applyNeuron(input int sum);
		int result;
		if (sum < 0)
			return 0;
		result = (sum >>> fracShift) + ((sum >>> (fracShift - 1)) & 1);
		if (result > actMax)
			result = actMax;
		return result;
	endfunction

	function automatic void classify(
		input logic [pixelCount-1:0][actWidth-1:0] sample,
		output int bestId,
		output int bestScore
	);
		int hidden [hiddenCount];
		int score [classCount];
		int sum;
		for (int h = 0; h < hiddenCount; h++)
		begin
			sum = int'($signed(hiddenBias[h]));
			for (int p = 0; p < pixelCount; p++)
				sum += (int'(sample[p]) / 2) * int'($signed(hiddenWeights[h][p]));
			hidden[h] = applyNeuron(sum);
		end
		for (int c = 0; c < classCount; c++)
		begin
			sum = int'($signed(outputBias[c]));
			for (int h = 0; h < hiddenCount; h++)
				sum += hidden[h] * int'($signed(outputWeights[c][h]));
			score[c] = applyNeuron(sum);
		end
		// First maximum wins
		bestId = 0;
		bestScore = score[0];
		for (int c = 1; c < classCount; c++)
		begin
			if (score[c] > bestScore)
			begin
				bestId = c;
				bestScore = score[c];
			end
		end
	endfunction

	always @(posedge clk)
	begin
		// Outputs stay cleared through reset and the first cycle after it
		if (resetQ || resetQQ)
		begin
			if (resultValid !== 1'b0 || classId !== '0 || classScore !== '0)
			begin
				$display("ERROR reset: expected all 0, actual valid %b class %0d score %0d",
					resultValid, classId, classScore);
				valueErrors++;
			end
		end
		resetQ <= reset;
		resetQQ <= resetQ;

		// Pop before push, so a result in the same cycle as its sample counts as extra
		if (!reset && resultValid)
		begin
			if (expIds.size() == 0)
			begin
				$display("Unexpected result with class %0d and score %0d, no sample was waiting",
					classId, classScore);
				protocolErrors++;
			end
			else
			begin
				expId = expIds.pop_front();
				expScore = expScores.pop_front();
				expTest = expTests.pop_front();
				checkedCount++;
				if (int'(classId) != expId)
				begin
					$display("ERROR %s classId: expected %0d, actual %0d",
						testName(expTest), expId, classId);
					valueErrors++;
				end
				if (int'(classScore) != expScore)
				begin
					$display("ERROR %s classScore: expected %0d, actual %0d",
						testName(expTest), expScore, classScore);
					valueErrors++;
				end
			end
		end

		if (!reset && sampleValid)
		begin
			classify(pixels, expId, expScore);
			expIds.push_back(expId);
			expScores.push_back(expScore);
			expTests.push_back(testId);
		end
		pendingCount <= expIds.size();
	end

endmodule

`default_nettype wire

// File: verification/nnClassifier_props.sv
`timescale 1ns/100ps
`default_nettype none

module nnClassifierProps (
	input logic clk,
	input logic reset,
	input logic sampleValid,
	input logic resultValid,
	input logic [nnPkg::classIdWidth-1:0] classId
);
	import nnPkg::*;

	// Fixed pipeline depth in both directions
	resultFollowsSample: assert property (@(posedge clk) disable iff (reset)
		$past(sampleValid, pipeLatency) |-> resultValid)
		else $error("resultValid did not follow sampleValid after pipeLatency cycles");

	noStrayResult: assert property (@(posedge clk) disable iff (reset)
		resultValid |-> $past(sampleValid, pipeLatency))
		else $error("resultValid without a sampleValid pipeLatency cycles earlier");

	classIdInRange: assert property (@(posedge clk) disable iff (reset)
		resultValid |-> (classId < classCount))
		else $error("classId out of range while resultValid is high");

	quietInReset: assert property (@(posedge clk) reset |=> !resultValid)
		else $error("resultValid high during reset");

	quietAfterReset: assert property (@(posedge clk) $fell(reset) |=> !resultValid)
		else $error("resultValid high in the cycle after reset");

endmodule

bind nnClassifier nnClassifierProps u_props (
	.clk(clk),
	.reset(reset),
	.sampleValid(sampleValid),
	.resultValid(resultValid),
	.classId(classId)
);

`default_nettype wire

// File: verification/nnClassifierTb.sv
`timescale 1ns/100ps
`default_nettype none

module nnClassifierTb;
	import nnPkg::*;

	localparam int resetCycles = 8;
	// Ids match the names in nnClassifierChecker
	localparam int testCorner = 0;
	localparam int testBurst = 1;
	localparam int testNegative = 2;
	localparam int testRandom = 3;
	localparam int cornerCount = 3;
	localparam int burstCount = 12;
	localparam int negativeCount = 4;
	localparam int randomCount = 200;
	localparam int sampleCount = cornerCount + burstCount + negativeCount + randomCount;
	localparam int watchdogCycles = (sampleCount + pipeLatency + 20) * 2;

	logic clk;
	logic reset;
	logic sampleValid;
	logic [pixelCount-1:0][actWidth-1:0] pixels;
	logic resultValid;
	logic [classIdWidth-1:0] classId;
	logic [actWidth-1:0] classScore;
	int testId;
	int valueErrors;
	int protocolErrors;
	int checkedCount;
	int pendingCount;
	int endErrors;
	logic [15:0] lfsrState;

	nnClassifier u_dut (
		.clk(clk),
		.reset(reset),
		.sampleValid(sampleValid),
		.pixels(pixels),
		.resultValid(resultValid),
		.classId(classId),
		.classScore(classScore)
	);

	nnClassifierChecker u_checker (
		.clk(clk),
		.reset(reset),
		.sampleValid(sampleValid),
		.pixels(pixels),
		.testId(testId),
		.resultValid(resultValid),
		.classId(classId),
		.classScore(classScore),
		.valueErrors(valueErrors),
		.protocolErrors(protocolErrors),
		.checkedCount(checkedCount),
		.pendingCount(pendingCount)
	);

	always #5 clk = ~clk;

	// Galois LFSR with polynomial x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsrStep(input logic [15:0] state);
		if (state[0])
			return (state >> 1) ^ 16'hB400;
		return state >> 1;
	endfunction

	function automatic int takeBits(input int count);
		int value;
		value = 0;
		for (int i = 0; i < count; i++)
		begin
			value = (value << 1) | int'(lfsrState[0]);
			lfsrState = lfsrStep(lfsrState);
		end
		return value;
	endfunction

	function automatic logic [pixelCount-1:0][actWidth-1:0] randomSample();
		logic [pixelCount-1:0][actWidth-1:0] sample;
		for (int p = 0; p < pixelCount; p++)
			sample[p] = actWidth'(takeBits(actWidth));
		return sample;
	endfunction

	// Full-scale pixel where the mask bit is set, zero elsewhere
	function automatic logic [pixelCount-1:0][actWidth-1:0] maskSample(
		input logic [pixelCount-1:0] mask
	);
		logic [pixelCount-1:0][actWidth-1:0] sample;
		for (int p = 0; p < pixelCount; p++)
			sample[p] = mask[p] ? 8'hFF : 8'h00;
		return sample;
	endfunction

	task automatic sendSample(input logic [pixelCount-1:0][actWidth-1:0] sample, input int id);
		@(posedge clk);
		sampleValid <= 1'b1;
		pixels <= sample;
		testId <= id;
	endtask

	task automatic idleCycle();
		@(posedge clk);
		sampleValid <= 1'b0;
	endtask

	// Let the pipeline empty before the next group
	task automatic drainPipeline();
		idleCycle();
		@(posedge clk);
		while (pendingCount != 0)
			@(posedge clk);
	endtask

	initial
	begin
		repeat (watchdogCycles) @(posedge clk);
		$display("Timeout after %0d cycles with %0d samples still waiting for a result",
			watchdogCycles, pendingCount);
		$display("TESTS FAILED");
		$finish;
	end

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		sampleValid = 1'b0;
		pixels = '0;
		testId = 0;
		endErrors = 0;
		lfsrState = 16'd52486;
		repeat (resetCycles) @(posedge clk);
		reset <= 1'b0;
		repeat (2) idleCycle();

		// Biases alone, every pixel at full scale, then only the positive weights of row 3
		// which drive hidden neuron 3 into saturation
		sendSample(maskSample(10'h000), testCorner);
		sendSample(maskSample(10'h3FF), testCorner);
		sendSample(maskSample(10'h12A), testCorner);
		drainPipeline();

		// More samples than pipeline stages, all back to back
		for (int i = 0; i < burstCount; i++)
			sendSample(randomSample(), testBurst);
		drainPipeline();

		// Light up the pixels with negative weights of rows 3, 0, 2 and 1
		sendSample(maskSample(10'h2D5), testNegative);
		sendSample(maskSample(10'h124), testNegative);
		sendSample(maskSample(10'h2AA), testNegative);
		sendSample(maskSample(10'h249), testNegative);
		drainPipeline();

		for (int i = 0; i < randomCount; i++)
		begin
			sendSample(randomSample(), testRandom);
			if (takeBits(2) == 3)
				idleCycle();
		end
		drainPipeline();

		// Room for any stray result to show up
		repeat (pipeLatency + 2) @(posedge clk);
		if (pendingCount != 0)
		begin
			$display("%0d samples never produced a result", pendingCount);
			endErrors++;
		end
		if (checkedCount != sampleCount)
		begin
			$display("Sent %0d samples but only %0d results were checked",
				sampleCount, checkedCount);
			endErrors++;
		end
		$display("Checked %0d results: %0d value errors, %0d protocol errors, %0d end errors",
			checkedCount, valueErrors, protocolErrors, endErrors);
		if (valueErrors == 0 && protocolErrors == 0 && endErrors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: nnClassifier.f
logic/nnPkg.sv
logic/pixelCapture.sv
logic/neuronNode.sv
logic/denseLayer.sv
logic/classSelect.sv
logic/nnClassifier.sv
verification/nnClassifierChecker.sv
verification/nnClassifier_props.sv
verification/nnClassifierTb.sv

// File: Makefile
SOURCES := $(shell cat nnClassifier.f)

.PHONY: all run clean

all: obj_dir/VnnClassifierTb

obj_dir/VnnClassifierTb: nnClassifier.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal --top-module nnClassifierTb \
		-f nnClassifier.f

run: obj_dir/VnnClassifierTb
	@out="$$(./obj_dir/VnnClassifierTb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf obj_dir
